/* verilog/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// major opcode in bits 31:26
	typedef enum logic [5:0] {
		op_add  = 6'h01,
		op_sub  = 6'h02,
		op_and  = 6'h03,
		op_or   = 6'h04,
		op_xor  = 6'h05,
		op_slt  = 6'h06,
		op_sltu = 6'h07,
		op_sll  = 6'h08,
		op_srl  = 6'h09,
		op_sra  = 6'h0a,
		op_addi = 6'h10,
		op_andi = 6'h11,
		op_ori  = 6'h12,
		op_lui  = 6'h13,
		op_beq  = 6'h20,
		op_bne  = 6'h21,
		op_bl   = 6'h22
	} opcode_t;

	typedef logic [4:0] reg_addr_t;

	typedef struct packed {
		opcode_t     opcode;
		reg_addr_t   rd;
		reg_addr_t   rj;
		reg_addr_t   rk;
		logic [10:0] unused;
	} r_form_t;

	typedef struct packed {
		opcode_t     opcode;
		reg_addr_t   rd;
		reg_addr_t   rj;
		logic [15:0] imm16;
	} i_form_t;

	// same word, register view and immediate view
	typedef union packed {
		r_form_t r;
		i_form_t i;
	} inst_t;

endpackage

`default_nettype wire

/* verilog/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_slt  = 4'd5,
		alu_sltu = 4'd6,
		alu_sll  = 4'd7,
		alu_srl  = 4'd8,
		alu_sra  = 4'd9,
		alu_lui  = 4'd10 // passes operand b through
	} alu_op_t;

	typedef enum logic [1:0] {
		br_none = 2'd0,
		br_beq  = 2'd1,
		br_bne  = 2'd2,
		br_bl   = 2'd3
	} br_kind_t;

	// second alu operand
	typedef enum logic {
		src_b_reg = 1'b0,
		src_b_imm = 1'b1
	} src_b_t;

endpackage

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import isa_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  reg_addr_t   ra_a_i,
	input  reg_addr_t   ra_b_i,
	output logic [31:0] rd_a_o,
	output logic [31:0] rd_b_o,
	input  logic        we_i,
	input  reg_addr_t   wa_i,
	input  logic [31:0] wd_i
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && wa_i != '0) begin
			regs[wa_i] <= wd_i;
		end
	end

	// write-through so an issue sees the value retiring in the same cycle
	always_comb begin
		if (ra_a_i == '0) rd_a_o = '0;
		else if (we_i && wa_i == ra_a_i) rd_a_o = wd_i;
		else rd_a_o = regs[ra_a_i];
	end

	always_comb begin
		if (ra_b_i == '0) rd_b_o = '0;
		else if (we_i && wa_i == ra_b_i) rd_b_o = wd_i;
		else rd_b_o = regs[ra_b_i];
	end

endmodule

`default_nettype wire

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
	input  inst_t       inst_i,
	output reg_addr_t   rj_o,
	output reg_addr_t   rk_o,
	output reg_addr_t   rd_o,
	output logic [31:0] imm_o,
	output alu_op_t     alu_op_o,
	output src_b_t      src_b_o,
	output br_kind_t    br_kind_o,
	output logic        wr_en_o
);

	logic [31:0] imm_sext;
	logic [31:0] imm_zext;

	assign imm_sext = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
	assign imm_zext = {16'h0000, inst_i.i.imm16};

	always_comb begin
		rj_o      = inst_i.r.rj;
		rk_o      = inst_i.r.rk; // register view
		rd_o      = inst_i.r.rd;
		imm_o     = '0;
		alu_op_o  = alu_add;
		src_b_o   = src_b_reg;
		br_kind_o = br_none;
		wr_en_o   = 1'b1; // most ops write rd

		case (inst_i.r.opcode)
			op_add:  alu_op_o = alu_add;
			op_sub:  alu_op_o = alu_sub;
			op_and:  alu_op_o = alu_and;
			op_or:   alu_op_o = alu_or;
			op_xor:  alu_op_o = alu_xor;
			op_slt:  alu_op_o = alu_slt;
			op_sltu: alu_op_o = alu_sltu;
			op_sll:  alu_op_o = alu_sll;
			op_srl:  alu_op_o = alu_srl;
			op_sra:  alu_op_o = alu_sra;
			op_addi: begin
				src_b_o = src_b_imm;
				imm_o   = imm_sext;
			end
			op_andi: begin
				alu_op_o = alu_and;
				src_b_o  = src_b_imm;
				imm_o    = imm_zext;
			end
			op_ori: begin
				alu_op_o = alu_or;
				src_b_o  = src_b_imm;
				imm_o    = imm_zext;
			end
			op_lui: begin
				alu_op_o = alu_lui;
				src_b_o  = src_b_imm;
				imm_o    = {inst_i.i.imm16, 16'h0000};
			end
			// compare rj against the rd field, read through port b
			op_beq, op_bne: begin
				rk_o      = inst_i.i.rd;
				imm_o     = imm_sext;
				br_kind_o = (inst_i.i.opcode == op_beq) ? br_beq : br_bne;
				wr_en_o   = 1'b0;
			end
			op_bl: begin
				rd_o      = 5'd1; // link register
				imm_o     = imm_sext;
				br_kind_o = br_bl;
			end
			default: wr_en_o = 1'b0; // unknown op acts as a nop
		endcase
	end

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit import pipe_pkg::*; (
	input  logic [31:0] op_a_i,
	input  logic [31:0] op_b_i,
	input  logic [31:0] imm_i,
	input  logic [31:0] pc_i,
	input  alu_op_t     alu_op_i,
	input  src_b_t      src_b_i,
	input  br_kind_t    br_kind_i,
	output logic [31:0] result_o,
	output logic        taken_o,
	output logic [31:0] target_o
);

	logic [31:0] alu_b;
	logic [31:0] alu_res;
	logic [31:0] seq_pc;
	logic [4:0]  shamt;

	assign alu_b = (src_b_i == src_b_imm) ? imm_i : op_b_i;
	assign shamt = alu_b[4:0];

	always_comb begin
		case (alu_op_i)
			alu_add:  alu_res = op_a_i + alu_b;
			alu_sub:  alu_res = op_a_i - alu_b;
			alu_and:  alu_res = op_a_i & alu_b;
			alu_or:   alu_res = op_a_i | alu_b;
			alu_xor:  alu_res = op_a_i ^ alu_b;
			alu_slt:  alu_res = {31'd0, $signed(op_a_i) < $signed(alu_b)};
			alu_sltu: alu_res = {31'd0, op_a_i < alu_b};
			alu_sll:  alu_res = op_a_i << shamt;
			alu_srl:  alu_res = op_a_i >> shamt;
			alu_sra:  alu_res = $signed(op_a_i) >>> shamt;
			alu_lui:  alu_res = alu_b; // already shifted by decode
			default:  alu_res = '0;
		endcase
	end

	assign seq_pc = pc_i + 32'd4;

	// bl returns the link address instead of the alu value
	assign result_o = (br_kind_i == br_bl) ? seq_pc : alu_res;

	// branches compare the raw register operands
	always_comb begin
		case (br_kind_i)
			br_beq:  taken_o = (op_a_i == op_b_i);
			br_bne:  taken_o = (op_a_i != op_b_i);
			br_bl:   taken_o = 1'b1;
			default: taken_o = 1'b0;
		endcase
	end

	assign target_o = pc_i + {imm_i[29:0], 2'b00}; // word offset

endmodule

`default_nettype wire

/* verilog/backend_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module backend_pipeline import isa_pkg::*, pipe_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        issue_i,
	input  logic        stall_i,
	input  logic [31:0] pc_i,
	input  reg_addr_t   rj_i,
	input  reg_addr_t   rk_i,
	input  reg_addr_t   rd_i,
	input  logic [31:0] rj_data_i,
	input  logic [31:0] rk_data_i,
	input  logic [31:0] imm_i,
	input  alu_op_t     alu_op_i,
	input  src_b_t      src_b_i,
	input  br_kind_t    br_kind_i,
	input  logic        wr_en_i,
	output logic        redirect_o,
	output logic [31:0] redirect_pc_o,
	output logic        wb_valid_o,
	output reg_addr_t   wb_addr_o,
	output logic [31:0] wb_data_o
);

	logic        issue_ok;
	logic        ex_valid, m1_valid, m2_valid, wb_valid;
	logic        ex_wr, m1_wr, m2_wr, wb_wr; // writes a nonzero rd
	reg_addr_t   ex_rj, ex_rk;
	reg_addr_t   ex_rd, m1_rd, m2_rd, wb_rd;
	logic [31:0] ex_pc, ex_imm, ex_a, ex_b;
	alu_op_t     ex_alu_op;
	src_b_t      ex_src_b;
	br_kind_t    ex_br_kind;
	logic [31:0] fwd_a, fwd_b;
	logic [31:0] ex_result, m1_data, m2_data, wb_data;
	logic        ex_taken;

	// slot behind a taken branch is squashed
	assign issue_ok = issue_i & ~redirect_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_wr    <= 1'b0;
		end else if (!stall_i) begin
			ex_valid <= issue_ok;
			ex_wr    <= wr_en_i & (rd_i != '0);
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			ex_pc      <= pc_i;
			ex_rj      <= rj_i;
			ex_rk      <= rk_i;
			ex_rd      <= rd_i;
			ex_imm     <= imm_i;
			ex_alu_op  <= alu_op_i;
			ex_src_b   <= src_b_i;
			ex_br_kind <= br_kind_i;
			ex_a       <= rj_data_i;
			ex_b       <= rk_data_i;
		end else begin
			// frozen ex keeps picking up producers that retire meanwhile
			ex_a <= fwd_a;
			ex_b <= fwd_b;
		end
	end

	// later assignment wins so m1 (youngest) has priority
	always_comb begin
		fwd_a = ex_a;
		fwd_b = ex_b;
		if (wb_valid && wb_wr && wb_rd == ex_rj) fwd_a = wb_data;
		if (m2_valid && m2_wr && m2_rd == ex_rj) fwd_a = m2_data;
		if (m1_valid && m1_wr && m1_rd == ex_rj) fwd_a = m1_data;
		if (wb_valid && wb_wr && wb_rd == ex_rk) fwd_b = wb_data;
		if (m2_valid && m2_wr && m2_rd == ex_rk) fwd_b = m2_data;
		if (m1_valid && m1_wr && m1_rd == ex_rk) fwd_b = m1_data;
	end

	exec_unit i_exec_unit (
		.op_a_i    (fwd_a),
		.op_b_i    (fwd_b),
		.imm_i     (ex_imm),
		.pc_i      (ex_pc),
		.alu_op_i  (ex_alu_op),
		.src_b_i   (ex_src_b),
		.br_kind_i (ex_br_kind),
		.result_o  (ex_result),
		.taken_o   (ex_taken),
		.target_o  (redirect_pc_o)
	);

	assign redirect_o = ex_valid & ex_taken;

	// m1 and m2 just carry the result
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_valid <= 1'b0;
			m1_wr    <= 1'b0;
			m2_valid <= 1'b0;
			m2_wr    <= 1'b0;
		end else if (!stall_i) begin
			m1_valid <= ex_valid;
			m1_wr    <= ex_wr;
			m2_valid <= m1_valid;
			m2_wr    <= m1_wr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			m1_rd   <= ex_rd;
			m1_data <= ex_result;
			m2_rd   <= m1_rd;
			m2_data <= m1_data;
		end
	end

	// result stage takes a bubble while stalled
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_wr    <= 1'b0;
		end else begin
			wb_valid <= m2_valid & ~stall_i;
			wb_wr    <= m2_wr;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd   <= m2_rd;
		wb_data <= m2_data;
	end

	assign wb_valid_o = wb_valid & wb_wr;
	assign wb_addr_o  = wb_rd;
	assign wb_data_o  = wb_data;

endmodule

`default_nettype wire

/* verilog/backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module backend_top import isa_pkg::*, pipe_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        issue_i,
	input  inst_t       inst_i,
	input  logic [31:0] pc_i,
	input  logic        stall_i,
	output logic        redirect_o,
	output logic [31:0] redirect_pc_o,
	output logic        wb_valid_o,
	output reg_addr_t   wb_addr_o,
	output logic [31:0] wb_data_o
);

	reg_addr_t   dec_rj, dec_rk, dec_rd;
	logic [31:0] dec_imm;
	alu_op_t     dec_alu_op;
	src_b_t      dec_src_b;
	br_kind_t    dec_br_kind;
	logic        dec_wr_en;
	logic [31:0] rj_data, rk_data;

	inst_decoder i_inst_decoder (
		.inst_i    (inst_i),
		.rj_o      (dec_rj),
		.rk_o      (dec_rk),
		.rd_o      (dec_rd),
		.imm_o     (dec_imm),
		.alu_op_o  (dec_alu_op),
		.src_b_o   (dec_src_b),
		.br_kind_o (dec_br_kind),
		.wr_en_o   (dec_wr_en)
	);

	// write port is driven straight from the wb stage
	reg_file i_reg_file (
		.clk    (clk),
		.rst_n  (rst_n),
		.ra_a_i (dec_rj),
		.ra_b_i (dec_rk),
		.rd_a_o (rj_data),
		.rd_b_o (rk_data),
		.we_i   (wb_valid_o),
		.wa_i   (wb_addr_o),
		.wd_i   (wb_data_o)
	);

	backend_pipeline i_backend_pipeline (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_i       (issue_i),
		.stall_i       (stall_i),
		.pc_i          (pc_i),
		.rj_i          (dec_rj),
		.rk_i          (dec_rk),
		.rd_i          (dec_rd),
		.rj_data_i     (rj_data),
		.rk_data_i     (rk_data),
		.imm_i         (dec_imm),
		.alu_op_i      (dec_alu_op),
		.src_b_i       (dec_src_b),
		.br_kind_i     (dec_br_kind),
		.wr_en_i       (dec_wr_en),
		.redirect_o    (redirect_o),
		.redirect_pc_o (redirect_pc_o),
		.wb_valid_o    (wb_valid_o),
		.wb_addr_o     (wb_addr_o),
		.wb_data_o     (wb_data_o)
	);

endmodule

`default_nettype wire

/* dv/backend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module backend_tb;

	logic        clk;
	logic        rst_n;
	logic        issue_i;
	logic [31:0] inst_i;
	logic [31:0] pc_i;
	logic        stall_i;
	logic        redirect_o;
	logic [31:0] redirect_pc_o;
	logic        wb_valid_o;
	logic [4:0]  wb_addr_o;
	logic [31:0] wb_data_o;

	// golden record kind codes I=0 S=1 W=2 R=3 E=4 T=5
	int          op_kind[$];
	logic [31:0] op_a[$];
	logic [31:0] op_b[$];
	string       test_name[$];
	int          test_stall[$];

	logic [4:0]  exp_addr[$];
	logic [31:0] exp_data[$];
	logic [31:0] exp_tgt[$];
	logic [4:0]  got_addr[$];
	logic [31:0] got_data[$];
	logic [31:0] got_tgt[$];

	integer seed = 80336;
	int     errors = 0;
	int     tests_pass = 0;
	int     tests_fail = 0;
	int     test_errors;
	int     limit_cycles = 200;
	logic   any_issued = 1'b0;
	logic   redirect_q = 1'b0;

	backend_top i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_i       (issue_i),
		.inst_i        (inst_i),
		.pc_i          (pc_i),
		.stall_i       (stall_i),
		.redirect_o    (redirect_o),
		.redirect_pc_o (redirect_pc_o),
		.wb_valid_o    (wb_valid_o),
		.wb_addr_o     (wb_addr_o),
		.wb_data_o     (wb_data_o)
	);

	always #5 clk = ~clk;

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic drive_cycle(input logic iss, input logic [31:0] w, input logic [31:0] p,
			input logic st);
		@(posedge clk);
		#1;
		issue_i = iss;
		inst_i  = w;
		pc_i    = p;
		stall_i = st;
		if (iss) any_issued = 1'b1;
	endtask

	task automatic load_golden();
		int    fd;
		int    r;
		int    n_inst;
		string kind;
		string rest;
		string name;
		int    flag;
		logic [31:0] a;
		logic [31:0] b;
		n_inst = 0;
		fd = $fopen("dv/backend_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				r = $fscanf(fd, "%s", kind);
				if (r != 1) break;
				a = '0;
				b = '0;
				case (kind)
					"T": begin
						r = $fscanf(fd, "%s %d", name, flag);
						a = test_name.size();
						test_name.push_back(name);
						test_stall.push_back(flag);
						op_kind.push_back(5);
					end
					"I": begin
						r = $fscanf(fd, "%h %h", a, b);
						op_kind.push_back(0);
						n_inst++;
					end
					"S": begin
						r = $fscanf(fd, "%d", a);
						op_kind.push_back(1);
					end
					"W": begin
						r = $fscanf(fd, "%d %h", a, b);
						op_kind.push_back(2);
					end
					"R": begin
						r = $fscanf(fd, "%h", a);
						op_kind.push_back(3);
					end
					"E": op_kind.push_back(4);
					default: r = $fgets(rest, fd); // comment line
				endcase
				if (kind == "T" || kind == "I" || kind == "S" || kind == "W" ||
						kind == "R" || kind == "E") begin
					op_a.push_back(a);
					op_b.push_back(b);
				end
			end
			$fclose(fd);
			limit_cycles = 20 * n_inst + 200;
		end
	endtask

	task automatic finish_test(input string name);
		int n;
		drive_cycle(1'b0, '0, '0, 1'b0);
		while (got_addr.size() < exp_addr.size() || got_tgt.size() < exp_tgt.size()) begin
			drive_cycle(1'b0, '0, '0, 1'b0);
		end
		repeat (4) drive_cycle(1'b0, '0, '0, 1'b0); // pipe depth so late extras show up
		check("write count", got_addr.size(), exp_addr.size());
		check("redirect count", got_tgt.size(), exp_tgt.size());
		n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			check($sformatf("%s write %0d addr", name, i), 32'(got_addr[i]),
				32'(exp_addr[i]));
			check($sformatf("%s write %0d data", name, i), got_data[i], exp_data[i]);
		end
		n = (got_tgt.size() < exp_tgt.size()) ? got_tgt.size() : exp_tgt.size();
		for (int i = 0; i < n; i++) begin
			check($sformatf("%s redirect %0d", name, i), got_tgt[i], exp_tgt[i]);
		end
		if (test_errors == 0) tests_pass++;
		else tests_fail++;
		$display("test %s: %s, %0d writes, %0d redirects", name,
			(test_errors == 0) ? "pass" : "FAIL", got_addr.size(), got_tgt.size());
		exp_addr.delete();
		exp_data.delete();
		exp_tgt.delete();
		got_addr.delete();
		got_data.delete();
		got_tgt.delete();
	endtask

	// sample results at negedge away from the clock edge
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (!any_issued && (wb_valid_o || redirect_o)) begin
				$display("write-back or redirect seen before the first issue at %0t", $time);
				errors++;
			end
			if (wb_valid_o) begin
				got_addr.push_back(wb_addr_o);
				got_data.push_back(wb_data_o);
			end
			if (redirect_o && !redirect_q) got_tgt.push_back(redirect_pc_o);
			redirect_q = redirect_o;
		end
	end

	initial begin
		#1;
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("Errors found");
		$finish;
	end

	initial begin
		int    stall_on;
		int    gap;
		string name;
		clk      = 1'b0;
		rst_n    = 1'b0;
		issue_i  = 1'b0;
		inst_i   = '0;
		pc_i     = '0;
		stall_i  = 1'b0;
		stall_on = 0;
		load_golden();
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (3) drive_cycle(1'b0, '0, '0, 1'b0); // idle before the first issue
		for (int i = 0; i < op_kind.size(); i++) begin
			case (op_kind[i])
				5: begin
					name        = test_name[op_a[i]];
					stall_on    = test_stall[op_a[i]];
					test_errors = 0;
				end
				0: begin
					gap = stall_on ? ($unsigned($random(seed)) % 4) : 0;
					repeat (gap) drive_cycle(1'b0, '0, '0, 1'b1);
					drive_cycle(1'b1, op_a[i], op_b[i], 1'b0);
				end
				1: repeat (op_a[i]) drive_cycle(1'b0, '0, '0, 1'b0);
				2: begin
					exp_addr.push_back(op_a[i][4:0]);
					exp_data.push_back(op_b[i]);
				end
				3: exp_tgt.push_back(op_a[i]);
				default: finish_test(name);
			endcase
		end
		$display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
		if (errors == 0 && tests_fail == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/backend_golden.txt */
# T name stall_flag | I inst_hex pc_hex | S idle_cycles
# W reg data_hex | R redirect_target_hex | E end of test
T alu 0
I 4C408000 00000100
W 2 80000000
I 48421234 00000104
W 2 80001234
I 4060FFFF 00000108
W 3 FFFFFFFF
I 44838001 0000010C
W 4 00008001
I 04A21800 00000110
W 5 80001233
I 08C41000 00000114
W 6 80006DCD
I 0CE21800 00000118
W 7 80001234
I 15022000 0000011C
W 8 80009235
I 11243000 00000120
W 9 8000EDCD
I 19422000 00000124
W 10 00000001
I 1D622000 00000128
W 11 00000000
I 41800004 0000012C
W 12 00000004
I 21A46000 00000130
W 13 00080010
I 25C26000 00000134
W 14 08000123
I 29E26000 00000138
W 15 F8000123
E
T forward 0
I 42000010 00000200
W 16 00000010
I 06308000 00000204
W 17 00000020
I 06508800 00000208
W 18 00000030
I 06709000 0000020C
W 19 00000040
I 06908800 00000210
W 20 00000030
I 42A07FFF 00000214
W 21 00007FFF
S 1
I 0AD58000 00000218
W 22 00007FEF
S 2
I 16B6A800 0000021C
W 21 00000010
I 06F50000 00000220
W 23 00000010
I 43000001 00000224
W 24 00000001
I 43180001 00000228
W 24 00000002
I 43180001 0000022C
W 24 00000003
I 0738C000 00000230
W 25 00000006
E
T stall 1
I 43400123 00000300
W 26 00000123
I 077AD000 00000304
W 27 00000246
I 0B9BD000 00000308
W 28 00000123
I 17BCD800 0000030C
W 29 00000365
I 07DDD000 00000310
W 30 00000488
I 43180001 00000314
W 24 00000004
I 43180001 00000318
W 24 00000005
I 43180001 0000031C
W 24 00000006
I 0738C000 00000320
W 25 0000000C
E
T branch 0
I 82F00008 00000400
R 00000420
I 40400055 00000404
I 86F00004 00000420
I 40600066 00000424
W 3 00000066
I 8583FFFE 00000428
R 00000420
I 04A00000 0000042C
I 88000010 00000420
W 1 00000424
R 00000460
I 40800001 00000424
I 04C10000 00000460
W 6 00000424
E
T r0 0
I 40000077 00000500
I 04E00000 00000504
W 7 00000000
I 41000005 00000508
W 8 00000005
I 11280000 0000050C
W 9 00000005
E

/* flist.f */
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/reg_file.sv
verilog/inst_decoder.sv
verilog/exec_unit.sv
verilog/backend_pipeline.sv
verilog/backend_top.sv
dv/backend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module backend_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/Vbackend_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^No errors$"; then
	exit 0
else
	exit 1
fi
